// ==== hdl/channelBank.sv ====
`timescale 1ns/1ps

module channelBank (
   input  logic               DAC_CS,
   input  logic               reset,
   input  logic               clrN,
   input  logic               applyStrobe,
   input  dacLinkPkg::dacCmd  applyCmd,
   input  dacLinkPkg::dacAddr applyAddr,
   input  logic [11:0]        applyCode,
   output logic [11:0]        chanOut0,
   output logic [11:0]        chanOut1,
   output logic [11:0]        chanOut2,
   output logic [11:0]        chanOut3,
   output logic [3:0]         powerDown
);

   import dacLinkPkg::*;

   logic [11:0] inReg  [4];
   logic [11:0] outReg [4];
   logic [3:0]  sel;

   // Channel hit by the address, or all of them
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         sel[i] = (applyAddr == addrAll) || (applyAddr == dacAddr'(i));
      end
   end

   always_ff @(posedge DAC_CS) begin
      // clrN low zeros the bank on every low cycle
      if (reset || !clrN) begin
         for (int i = 0; i < 4; i++) begin
            inReg[i]  <= '0;
            outReg[i] <= '0;
         end
         powerDown <= '0;
      end else if (applyStrobe) begin
         for (int i = 0; i < 4; i++) begin
            case (applyCmd)
               cmdWrite: begin
                  if (sel[i]) begin
                     inReg[i] <= applyCode;
                  end
               end
               cmdUpdate: begin
                  if (sel[i]) begin
                     outReg[i]    <= inReg[i];
                     powerDown[i] <= 1'b0;
                  end
               end
               cmdWriteUpdate: begin
                  if (sel[i]) begin
                     inReg[i]     <= applyCode;
                     outReg[i]    <= applyCode;
                     powerDown[i] <= 1'b0;
                  end
               end
               // Write the addressed inputs, then update every channel
               cmdWriteUpdateAll: begin
                  if (sel[i]) begin
                     inReg[i]  <= applyCode;
                     outReg[i] <= applyCode;
                  end else begin
                     outReg[i] <= inReg[i];
                  end
                  powerDown[i] <= 1'b0;
               end
               cmdPowerDown: begin
                  if (sel[i]) begin
                     powerDown[i] <= 1'b1;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // Powered down channels read as zero
   assign chanOut0 = powerDown[0] ? 12'd0 : outReg[0];
   assign chanOut1 = powerDown[1] ? 12'd0 : outReg[1];
   assign chanOut2 = powerDown[2] ? 12'd0 : outReg[2];
   assign chanOut3 = powerDown[3] ? 12'd0 : outReg[3];

endmodule

// ==== hdl/dacLink.sv ====
`timescale 1ns/1ps

module dacLink (
   input  logic                   DAC_CS,
   input  logic                   reset,
   input  logic                   reqStrobe,
   input  logic [3:0]             reqCmd,
   input  logic [3:0]             reqAddr,
   input  logic [11:0]            reqCode,
   input  logic                   clrN,
   output logic                   overflow,
   output logic                   busy,
   output logic                   statusValid,
   output dacLinkPkg::frameStatus status,
   output logic                   echoValid,
   output logic [31:0]            echoWord,
   output logic [11:0]            chanOut0,
   output logic [11:0]            chanOut1,
   output logic [11:0]            chanOut2,
   output logic [11:0]            chanOut3,
   output logic [3:0]             powerDown
);

   import dacLinkPkg::*;

   // Queue to shifter
   logic        frameAvail;
   logic [31:0] frameWord;
   logic        framePop;
   logic        queueBusy;
   // Serial link
   logic        sck;
   logic        csN;
   logic        mosi;
   logic        miso;
   logic        shifting;
   // Receiver to channel bank
   logic        applyStrobe;
   dacCmd       applyCmd;
   dacAddr      applyAddr;
   logic [11:0] applyCode;

   // Queued or in flight
   assign busy = queueBusy | shifting;

   frameBuilder i_frameBuilder (
      .DAC_CS(DAC_CS), .reset(reset), .reqStrobe(reqStrobe), .reqCmd(reqCmd),
      .reqAddr(reqAddr), .reqCode(reqCode), .framePop(framePop),
      .frameAvail(frameAvail), .frameWord(frameWord), .overflow(overflow),
      .queueBusy(queueBusy)
   );

   spiShifter i_spiShifter (
      .DAC_CS(DAC_CS), .reset(reset), .frameAvail(frameAvail), .frameWord(frameWord),
      .miso(miso), .framePop(framePop), .sck(sck), .csN(csN), .mosi(mosi),
      .echoValid(echoValid), .echoWord(echoWord), .shifting(shifting)
   );

   frameReceiver i_frameReceiver (
      .DAC_CS(DAC_CS), .reset(reset), .clrN(clrN), .sck(sck), .csN(csN), .mosi(mosi),
      .miso(miso), .statusValid(statusValid), .status(status),
      .applyStrobe(applyStrobe), .applyCmd(applyCmd), .applyAddr(applyAddr),
      .applyCode(applyCode)
   );

   channelBank i_channelBank (
      .DAC_CS(DAC_CS), .reset(reset), .clrN(clrN), .applyStrobe(applyStrobe),
      .applyCmd(applyCmd), .applyAddr(applyAddr), .applyCode(applyCode),
      .chanOut0(chanOut0), .chanOut1(chanOut1), .chanOut2(chanOut2),
      .chanOut3(chanOut3), .powerDown(powerDown)
   );

endmodule

// ==== hdl/dacLinkPkg.sv ====
package dacLinkPkg;

   // Command nibble, frame bits 23..20
   typedef enum logic [3:0] {
      cmdWrite          = 4'b0000,
      cmdUpdate         = 4'b0001,
      cmdWriteUpdateAll = 4'b0010,
      cmdWriteUpdate    = 4'b0011,
      cmdPowerDown      = 4'b0100,
      cmdNop            = 4'b1111
   } dacCmd;

   // Address nibble, frame bits 19..16
   typedef enum logic [3:0] {
      addrA   = 4'd0,
      addrB   = 4'd1,
      addrC   = 4'd2,
      addrD   = 4'd3,
      addrAll = 4'd15
   } dacAddr;

   // Receiver verdict on a finished frame
   typedef enum logic [1:0] {
      statusOk,
      statusBadAddr,
      statusBadCmd,
      statusNotCleared
   } frameStatus;

   // Shifter sequencing
   typedef enum logic [1:0] {
      shIdle,
      shSelect,
      shShift,
      shRelease
   } shiftState;

   // Receiver clear tracking
   typedef enum logic [1:0] {
      rxWaitClr,
      rxClrLow,
      rxReady
   } rxState;

endpackage

// ==== hdl/dacLink_params.svh ====
`ifndef DACLINK_PARAMS_SVH
`define DACLINK_PARAMS_SVH

// System cycles per serial clock half period
// Any value of 1 or more gives a legal serial clock
`define SCK_HALF 2

// Entries in the host request queue
`define QUEUE_DEPTH 2

// Cycles clrN must stay low before its rise counts as a clear
`define CLR_MIN 4

// Bits in one frame, sent MSB first
`define FRAME_BITS 32

`endif

// ==== hdl/frameBuilder.sv ====
`timescale 1ns/1ps
`include "dacLink_params.svh"

module frameBuilder (
   input  logic        DAC_CS,
   input  logic        reset,
   input  logic        reqStrobe,
   input  logic [3:0]  reqCmd,
   input  logic [3:0]  reqAddr,
   input  logic [11:0] reqCode,
   input  logic        framePop,
   output logic        frameAvail,
   output logic [31:0] frameWord,
   output logic        overflow,
   output logic        queueBusy
);

   localparam int Depth = `QUEUE_DEPTH;
   localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
   localparam int CntW  = $clog2(Depth + 1);

   logic [31:0]     queueMem [Depth];
   logic [PtrW-1:0] wrPtr;
   logic [PtrW-1:0] rdPtr;
   logic [CntW-1:0] count;
   logic            full;
   logic            doPush;
   logic [31:0]     newFrame;

   // Circular pointer step, wraps at the last entry
   function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
      if (ptr == PtrW'(Depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // Zero top byte and zero low nibble around the fields
   assign newFrame = {8'h00, reqCmd, reqAddr, reqCode, 4'h0};

   assign full       = (count == CntW'(Depth));
   assign frameAvail = (count != '0);
   assign frameWord  = queueMem[rdPtr];
   assign queueBusy  = frameAvail;

   // A pop in the same cycle frees the slot the push lands in
   assign doPush = reqStrobe && (!full || framePop);

   always_ff @(posedge DAC_CS) begin
      if (doPush) begin
         queueMem[wrPtr] <= newFrame;
      end
   end

   always_ff @(posedge DAC_CS) begin
      if (reset) begin
         wrPtr    <= '0;
         rdPtr    <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         // One cycle pulse per dropped request
         overflow <= reqStrobe && !doPush;
         if (doPush) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (framePop) begin
            rdPtr <= nextPtr(rdPtr);
         end
         case ({doPush, framePop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Shifter must only take the head when one is there
   popNeedsFrame: assert property (@(posedge DAC_CS) disable iff (reset)
      framePop |-> frameAvail)
      else $error("frame taken from an empty request queue");

endmodule

// ==== hdl/frameReceiver.sv ====
`timescale 1ns/1ps
`include "dacLink_params.svh"

module frameReceiver (
   input  logic                   DAC_CS,
   input  logic                   reset,
   input  logic                   clrN,
   input  logic                   sck,
   input  logic                   csN,
   input  logic                   mosi,
   output logic                   miso,
   output logic                   statusValid,
   output dacLinkPkg::frameStatus status,
   output logic                   applyStrobe,
   output dacLinkPkg::dacCmd      applyCmd,
   output dacLinkPkg::dacAddr     applyAddr,
   output logic [11:0]            applyCode
);

   import dacLinkPkg::*;

   localparam int ClrW = $clog2(`CLR_MIN + 1);

   rxState          clrState;
   logic [ClrW-1:0] clrCnt;
   logic            clearDone;
   logic            sckPrev;
   logic            csNPrev;
   logic            sckRise;
   logic            csNRise;
   logic            csNFall;
   logic [31:0]     rxShift;
   logic [5:0]      bitCnt;
   logic            frameEnd;
   logic            addrOk;
   logic            cmdOk;
   frameStatus      frameClass;

   // Serial lines are registered copies, so edges are found by sampling
   assign sckRise = sck && !sckPrev;
   assign csNRise = csN && !csNPrev;
   assign csNFall = !csN && csNPrev;

   // Clear counts only when the low time reached the minimum
   assign clearDone = (clrState == rxClrLow) && clrN && (clrCnt == ClrW'(`CLR_MIN));

   // Shift register MSB goes back out while selected
   assign miso = csN ? 1'b0 : rxShift[31];

   always_comb begin
      case (rxShift[19:16])
         addrA, addrB, addrC, addrD, addrAll: addrOk = 1'b1;
         default: addrOk = 1'b0;
      endcase
      case (rxShift[23:20])
         cmdWrite, cmdUpdate, cmdWriteUpdateAll, cmdWriteUpdate, cmdPowerDown, cmdNop:
            cmdOk = 1'b1;
         default: cmdOk = 1'b0;
      endcase
      // Missing clear outranks address, address outranks command
      if (clrState != rxReady) begin
         frameClass = statusNotCleared;
      end else if (!addrOk) begin
         frameClass = statusBadAddr;
      end else if (!cmdOk) begin
         frameClass = statusBadCmd;
      end else begin
         frameClass = statusOk;
      end
   end

   always_ff @(posedge DAC_CS) begin
      if (reset) begin
         clrState    <= rxWaitClr;
         clrCnt      <= '0;
         sckPrev     <= 1'b0;
         csNPrev     <= 1'b1;
         rxShift     <= '0;
         bitCnt      <= '0;
         frameEnd    <= 1'b0;
         statusValid <= 1'b0;
         status      <= statusOk;
         applyStrobe <= 1'b0;
      end else begin
         sckPrev <= sck;
         csNPrev <= csN;
         // Any low clrN restarts the clear; a short one leaves the part uninitialized
         case (clrState)
            rxClrLow: begin
               if (!clrN) begin
                  if (clrCnt != ClrW'(`CLR_MIN)) begin
                     clrCnt <= clrCnt + 1'b1;
                  end
               end else begin
                  clrState <= clearDone ? rxReady : rxWaitClr;
               end
            end
            default: begin
               if (!clrN) begin
                  clrState <= rxClrLow;
                  clrCnt   <= ClrW'(1);
               end
            end
         endcase
         if (clearDone) begin
            rxShift <= '0;
         end else if (sckRise && !csN) begin
            rxShift <= {rxShift[30:0], mosi};
         end
         if (csNFall) begin
            bitCnt <= '0;
         end else if (sckRise && !csN) begin
            bitCnt <= bitCnt + 1'b1;
         end
         // Verdict one cycle after the csN rise is seen
         frameEnd    <= csNRise;
         statusValid <= frameEnd;
         applyStrobe <= frameEnd && (frameClass == statusOk);
         if (frameEnd) begin
            status <= frameClass;
         end
      end
   end

   // Decoded fields for the channel bank
   always_ff @(posedge DAC_CS) begin
      if (frameEnd) begin
         applyCmd  <= dacCmd'(rxShift[23:20]);
         applyAddr <= dacAddr'(rxShift[19:16]);
         applyCode <= rxShift[15:4];
      end
   end

   // Every frame from the shifter carries exactly 32 bits
   fullFrame: assert property (@(posedge DAC_CS) disable iff (reset)
      csNRise |-> (bitCnt == 6'(`FRAME_BITS)))
      else $error("frame ended with a bit count other than 32");

endmodule

// ==== hdl/spiShifter.sv ====
`timescale 1ns/1ps
`include "dacLink_params.svh"

module spiShifter (
   input  logic        DAC_CS,
   input  logic        reset,
   input  logic        frameAvail,
   input  logic [31:0] frameWord,
   input  logic        miso,
   output logic        framePop,
   output logic        sck,
   output logic        csN,
   output logic        mosi,
   output logic        echoValid,
   output logic [31:0] echoWord,
   output logic        shifting
);

   import dacLinkPkg::*;

   localparam int HalfW = (`SCK_HALF > 1) ? $clog2(`SCK_HALF) : 1;

   shiftState        state;
   logic [HalfW-1:0] halfCnt;
   logic             halfDone;
   logic [4:0]       bitCnt;
   logic [31:0]      txShift;
   logic [31:0]      rxEcho;
   logic             sckRiseNext;
   logic             sckFallNext;

   assign halfDone = (halfCnt == HalfW'(`SCK_HALF - 1));

   // Head is taken as soon as the link is free
   assign framePop = (state == shIdle) && frameAvail;

   // Leading edge of each period comes from select or from a low half
   assign sckRiseNext = halfDone && ((state == shSelect) || (state == shShift && !sck));
   assign sckFallNext = halfDone && (state == shShift) && sck;

   assign mosi     = txShift[31];
   assign echoWord = rxEcho;
   assign shifting = (state != shIdle);

   always_ff @(posedge DAC_CS) begin
      if (reset) begin
         state     <= shIdle;
         halfCnt   <= '0;
         bitCnt    <= '0;
         sck       <= 1'b0;
         csN       <= 1'b1;
         echoValid <= 1'b0;
      end else begin
         echoValid <= 1'b0;
         // Half period timer, held at zero while idle
         if (state == shIdle || halfDone) begin
            halfCnt <= '0;
         end else begin
            halfCnt <= halfCnt + 1'b1;
         end
         case (state)
            shIdle: begin
               if (frameAvail) begin
                  csN    <= 1'b0;
                  bitCnt <= '0;
                  state  <= shSelect;
               end
            end
            // First low half doubles as chip select setup
            shSelect: begin
               if (halfDone) begin
                  sck   <= 1'b1;
                  state <= shShift;
               end
            end
            shShift: begin
               if (halfDone) begin
                  sck <= ~sck;
                  if (sck) begin
                     bitCnt <= bitCnt + 1'b1;
                     // 32nd falling edge ends the data phase
                     if (bitCnt == 5'd31) begin
                        state <= shRelease;
                     end
                  end
               end
            end
            shRelease: begin
               if (csN) begin
                  echoValid <= 1'b1;
                  state     <= shIdle;
               end else if (halfDone) begin
                  csN <= 1'b1;
               end
            end
            default: state <= shIdle;
         endcase
      end
   end

   // Data path, new bit after each falling edge
   always_ff @(posedge DAC_CS) begin
      if (framePop) begin
         txShift <= frameWord;
      end else if (sckFallNext) begin
         txShift <= {txShift[30:0], 1'b0};
      end
      // Echo bit taken as sck goes high
      if (sckRiseNext) begin
         rxEcho <= {rxEcho[30:0], miso};
      end
   end

   // Serial clock only toggles inside a selected frame
   sckIdleLow: assert property (@(posedge DAC_CS) disable iff (reset)
      csN |-> !sck)
      else $error("serial clock high while chip select is released");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the dacLink testbench with Verilator
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   -f sources.f --top-module dacLinkTb -o dacLinkSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dacLinkSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Done: errors found" "$logFile"; then
   echo "simulation reported errors"
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "simulator exited with status $simStatus"
   exit 1
fi
echo "simulation passed"
exit 0

// ==== sources.f ====
+incdir+hdl
hdl/dacLinkPkg.sv
hdl/frameBuilder.sv
hdl/spiShifter.sv
hdl/frameReceiver.sv
hdl/channelBank.sv
hdl/dacLink.sv
tests/dacLinkTb.sv

// ==== tests/dacLinkTb.sv ====
`timescale 1ns/1ps
`include "dacLink_params.svh"

module dacLinkTb;

   import dacLinkPkg::*;

   // DUT ports
   logic        DAC_CS;
   logic        reset;
   logic        reqStrobe;
   logic [3:0]  reqCmd;
   logic [3:0]  reqAddr;
   logic [11:0] reqCode;
   logic        clrN;
   logic        overflow;
   logic        busy;
   logic        statusValid;
   frameStatus  status;
   logic        echoValid;
   logic [31:0] echoWord;
   logic [11:0] chanOut0;
   logic [11:0] chanOut1;
   logic [11:0] chanOut2;
   logic [11:0] chanOut3;
   logic [3:0]  powerDown;

   // Reference model state
   logic [31:0] expFrames [$];
   logic [31:0] curFrame;
   logic [31:0] rxModel;
   logic        cleared;
   logic [11:0] mIn [4];
   logic [11:0] mOut [4];
   logic [3:0]  mPd;
   frameStatus  expStatus;
   // Bookkeeping
   int          acceptedTotal;
   int          statusSeen;
   int          dropExpected;
   int          dropSeen;
   logic        chanPending;

   dacLink i_dut (
      .DAC_CS(DAC_CS), .reset(reset), .reqStrobe(reqStrobe), .reqCmd(reqCmd),
      .reqAddr(reqAddr), .reqCode(reqCode), .clrN(clrN), .overflow(overflow),
      .busy(busy), .statusValid(statusValid), .status(status),
      .echoValid(echoValid), .echoWord(echoWord), .chanOut0(chanOut0),
      .chanOut1(chanOut1), .chanOut2(chanOut2), .chanOut3(chanOut3),
      .powerDown(powerDown)
   );

   // 100 ns system clock
   initial begin
      DAC_CS = 1'b0;
      forever #50 DAC_CS = ~DAC_CS;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         failRun($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h",
                           name, expected, actual));
      end
   endtask

   // Frame verdict with a missing clear ranked above address and command
   function automatic frameStatus classify(input logic [31:0] frame);
      logic addrOk;
      logic cmdOk;
      addrOk = (frame[19:16] <= 4'd3) || (frame[19:16] == 4'hF);
      cmdOk  = (frame[23:20] <= 4'd4) || (frame[23:20] == 4'hF);
      if (!cleared) begin
         return statusNotCleared;
      end else if (!addrOk) begin
         return statusBadAddr;
      end else if (!cmdOk) begin
         return statusBadCmd;
      end
      return statusOk;
   endfunction

   // Chip command semantics on the model registers
   task automatic applyFrame(input logic [31:0] frame);
      logic [3:0]  cmd;
      logic [3:0]  addr;
      logic [11:0] code;
      logic        sel;
      cmd  = frame[23:20];
      addr = frame[19:16];
      code = frame[15:4];
      for (int i = 0; i < 4; i++) begin
         sel = (addr == 4'hF) || (addr == 4'(i));
         case (cmd)
            cmdWrite: begin
               if (sel) mIn[i] = code;
            end
            cmdUpdate: begin
               if (sel) begin
                  mOut[i] = mIn[i];
                  mPd[i]  = 1'b0;
               end
            end
            cmdWriteUpdate: begin
               if (sel) begin
                  mIn[i]  = code;
                  mOut[i] = code;
                  mPd[i]  = 1'b0;
               end
            end
            // Addressed channels take the code, the rest copy their inputs
            cmdWriteUpdateAll: begin
               if (sel) begin
                  mIn[i]  = code;
                  mOut[i] = code;
               end else begin
                  mOut[i] = mIn[i];
               end
               mPd[i] = 1'b0;
            end
            cmdPowerDown: begin
               if (sel) mPd[i] = 1'b1;
            end
            default: ;
         endcase
      end
   endtask

   task automatic zeroChannels();
      for (int i = 0; i < 4; i++) begin
         mIn[i]  = '0;
         mOut[i] = '0;
      end
      mPd = '0;
   endtask

   // Powered down channels read zero
   function automatic logic [11:0] expectChan(input int i);
      return mPd[i] ? 12'd0 : mOut[i];
   endfunction

   task automatic compareChannels(input string when);
      check({when, " chanOut0"}, 32'(expectChan(0)), 32'(chanOut0));
      check({when, " chanOut1"}, 32'(expectChan(1)), 32'(chanOut1));
      check({when, " chanOut2"}, 32'(expectChan(2)), 32'(chanOut2));
      check({when, " chanOut3"}, 32'(expectChan(3)), 32'(chanOut3));
      check({when, " powerDown"}, 32'(mPd), 32'(powerDown));
   endtask

   // Mostly legal commands with an unlisted one now and then
   function automatic logic [3:0] pickCmd();
      case ($urandom_range(0, 7))
         0: return cmdWrite;
         1: return cmdUpdate;
         2: return cmdWriteUpdateAll;
         3: return cmdWriteUpdate;
         4: return cmdPowerDown;
         5: return cmdNop;
         default: return 4'($urandom_range(5, 14));
      endcase
   endfunction

   function automatic logic [3:0] pickAddr();
      case ($urandom_range(0, 6))
         0: return 4'd0;
         1: return 4'd1;
         2: return 4'd2;
         3: return 4'd3;
         4: return 4'hF;
         5: return 4'hF;
         default: return 4'($urandom_range(4, 14));
      endcase
   endfunction

   // Back to back requests from an idle link
   // Queue plus shifter hold QUEUE_DEPTH + 1 frames and drop the rest
   task automatic sendBurst(input int len);
      logic [3:0]  c;
      logic [3:0]  a;
      logic [11:0] code;
      for (int i = 0; i < len; i++) begin
         @(negedge DAC_CS);
         c    = pickCmd();
         a    = pickAddr();
         code = 12'($urandom);
         reqStrobe = 1'b1;
         reqCmd    = c;
         reqAddr   = a;
         reqCode   = code;
         if (i < `QUEUE_DEPTH + 1) begin
            expFrames.push_back({8'h00, c, a, code, 4'h0});
            acceptedTotal++;
         end else begin
            dropExpected++;
         end
      end
      @(negedge DAC_CS);
      reqStrobe = 1'b0;
   endtask

   // Wait until the link drains and every status and channel compare is done
   task automatic waitIdle(input string what);
      int cycles;
      cycles = 0;
      while (busy || statusSeen != acceptedTotal || chanPending) begin
         @(negedge DAC_CS);
         cycles++;
         if (cycles > 3000) begin
            failRun({"timeout: link never went idle after ", what});
         end
      end
      check({what, " overflow pulses"}, 32'(dropExpected), 32'(dropSeen));
      check({what, " frames without echo"}, 32'd0, 32'(expFrames.size()));
   endtask

   // Hold clrN low for lowCycles clocks and expect a clear only from CLR_MIN on
   task automatic pulseClear(input int lowCycles);
      @(negedge DAC_CS);
      clrN = 1'b0;
      repeat (lowCycles) @(negedge DAC_CS);
      clrN = 1'b1;
      zeroChannels();
      if (lowCycles >= `CLR_MIN) begin
         cleared = 1'b1;
         rxModel = '0;
      end else begin
         cleared = 1'b0;
      end
      @(negedge DAC_CS);
      compareChannels("after clear");
   endtask

   // Output monitor on the falling edge
   always @(negedge DAC_CS) begin
      if (!reset) begin
         if (overflow) dropSeen++;
         if (chanPending) begin
            compareChannels($sformatf("after frame %0d", statusSeen));
            chanPending = 1'b0;
         end
         // Echo carries what the receiver held before this frame
         if (echoValid) begin
            if (expFrames.size() == 0) begin
               failRun("echo pulse arrived with no frame outstanding");
            end else begin
               check($sformatf("echo of frame %0d", statusSeen), rxModel, echoWord);
               curFrame = expFrames.pop_front();
               rxModel  = curFrame;
            end
         end
         if (statusValid) begin
            expStatus = classify(curFrame);
            check($sformatf("status of frame %0d", statusSeen), 32'(expStatus),
                  32'(status));
            if (expStatus == statusOk) applyFrame(curFrame);
            statusSeen++;
            chanPending = 1'b1;
            if (expFrames.size() == 0) check("busy after last status", 32'd0, 32'(busy));
         end
      end
   end

   initial begin
      int n;
      void'($urandom(32'h06c5_b921));
      reset     = 1'b1;
      reqStrobe = 1'b0;
      reqCmd    = '0;
      reqAddr   = '0;
      reqCode   = '0;
      clrN      = 1'b1;
      cleared   = 1'b0;
      rxModel   = '0;
      curFrame  = '0;
      acceptedTotal = 0;
      statusSeen    = 0;
      dropExpected  = 0;
      dropSeen      = 0;
      chanPending   = 1'b0;
      zeroChannels();
      repeat (2) @(negedge DAC_CS);
      reset = 1'b0;
      compareChannels("after reset");
      // Receiver not yet cleared
      for (n = 0; n < 3; n++) begin
         sendBurst($urandom_range(1, 4));
         waitIdle("uncleared burst");
      end
      pulseClear($urandom_range(1, `CLR_MIN - 1));
      sendBurst(2);
      waitIdle("burst after short clear");
      pulseClear(`CLR_MIN);
      // Random bursts with the odd clear in between
      for (n = 0; n < 40; n++) begin
         case ($urandom_range(0, 11))
            0: pulseClear($urandom_range(`CLR_MIN, `CLR_MIN + 3));
            1: pulseClear($urandom_range(1, `CLR_MIN - 1));
            default: ;
         endcase
         sendBurst($urandom_range(1, 5));
         waitIdle("random burst");
      end
      $display("Done: no errors");
      $finish;
   end

endmodule
